// File: all.f
+incdir+include
logic/game_pkg.sv
logic/audio_pkg.sv
logic/game_config.sv
logic/stick_quantizer.sv
logic/control_mapper.sv
logic/video_timing.sv
logic/speech_lpf.sv
logic/audio_mixer.sv
logic/arcade_io_top.sv
tb/tb_arcade_io_top.sv

// File: tb/tb_arcade_io_top.sv
// Testbench for the Williams I/O glue
// Reference models for configuration, control mapping, stick latch,
// video counters and the audio sum, checked by concurrent assertions
`timescale 1ns/1ns
`default_nettype none

module tb_arcade_io_top;
	import game_pkg::*;

	localparam int TEST_CYCLES = 100 + 8 * (4 * 30 + 4) + 120 + 290 * 900 + 210 + 100 * 256;
	localparam longint WATCHDOG_NS = longint'(TEST_CYCLES + 2000) * 20;

	logic clk_sys = 1'b0;
	logic rst_n;
	logic dl_wr;
	logic [7:0] dl_index;
	logic [24:0] dl_addr;
	logic [7:0] dl_data;
	joy_word_t joy1;
	joy_word_t joy2;
	logic [15:0] joy1_analog;
	logic [15:0] joy2_analog;
	ctrl_mode_e ctrl_mode;
	logic sg_state;
	logic hs;
	logic vs;
	logic [7:0] game_audio;
	logic [15:0] speech;
	ctrl_byte_t ja;
	ctrl_byte_t jb;
	logic [2:0] btn;
	logic [7:0] sw;
	logic blitter_sc2, sinistar, landscape, sin_fire, sin_bomb;
	logic hblank, vblank, ce_pix;
	logic [15:0] audio_l;

	// Reference state
	logic [7:0] exp_game;
	logic [7:0] exp_dip;
	logic exp_p2;
	logic [18:0] exp_map;
	logic [2:0] exp_flags;
	logic [7:0] exp_sw;
	logic [1:0] exp_sin;
	logic [15:0] exp_audio;
	logic aud_raw_ok;
	logic sin_chk;
	logic [15:0] aud_diff;
	logic m_hs_d, m_vs_line, m_hblank, m_vblank;
	logic [10:0] m_pcnt;
	logic [10:0] m_lcnt;
	logic [31:0] rng;
	int errors;
	int tests;
	string test_name;

	arcade_io_top u_dut (.*);

	always #10 clk_sys = ~clk_sys;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Stick position code for one axis, X orientation
	function automatic logic [3:0] stick_code(input int v);
		if (v < -96) return 4'd0;
		if (v < -64) return 4'd4;
		if (v < -32) return 4'd6;
		if (v > 96) return 4'd8;
		if (v > 64) return 4'd9;
		if (v > 32) return 4'd11;
		return 4'd7;
	endfunction

	// Expected {ja, jb, btn}; joystick bits 0..3 are right/left/down/up
	function automatic logic [18:0] map_ref(input logic [7:0] g, input logic [1:0] mode,
		input logic [15:0] a, input logic [15:0] b, input logic sg,
		input logic [3:0] sx, input logic [3:0] sy);
		logic [15:0] o;
		logic [3:0] da, db, dm, fm;
		logic thr, rev;
		logic [3:0] px, py;
		logic [7:0] ra, rb;
		logic [2:0] bt;
		o = a | b;
		da = {a[0], a[1], a[2], a[3]};
		db = {b[0], b[1], b[2], b[3]};
		dm = {o[0], o[1], o[2], o[3]};
		fm = {o[4], o[7], o[5], o[6]};
		bt = {o[10], o[11], o[12]};
		ra = 8'h00;
		rb = 8'h00;
		case (g)
			8'd0: ra = mode[1] ? {db, da} : {mode[0] ? dm : fm, dm};
			8'd1:
			begin
				bt = {o[11], o[10], o[12]};
				ra = {5'b0, a[4], a[0], a[1]};
				rb = {5'b0, b[4], b[0], b[1]};
			end
			8'd2:
			begin
				ra = {mode[0] ? da : {a[4], a[7], a[5], a[6]}, da};
				rb = {mode[0] ? db : {b[4], b[7], b[5], b[6]}, db};
			end
			8'd3:
			begin
				bt = {o[11], o[10], o[12]};
				ra = {4'b0, dm};
			end
			8'd4:
			begin
				bt = {o[11], o[10], o[12]};
				thr = (mode == 2'd2) ? o[8] : mode[0] ? (sg ? o[0] : o[1]) : (o[0] | o[1]);
				rev = mode[0] ? (sg ? o[1] : o[0]) : o[5];
				ra = {o[9], o[3], o[2], thr, o[7], o[6], rev, o[4]};
			end
			8'd5:
			begin
				ra = {2'b0, a[5], a[4], da};
				rb = {2'b0, b[5], b[4], db};
			end
			8'd6:
			begin
				px = (sx != 4'd7) ? sx : o[1] ? 4'd0 : o[0] ? 4'd8 : 4'd7;
				py = (sy != 4'd7) ? sy : o[2] ? 4'd0 : o[3] ? 4'd8 : 4'd7;
				ra = {px, py};
			end
			default:
			begin
				bt = {2'b0, o[12]};
				ra = {4'b0, o[11], o[0], o[1], o[10]};
			end
		endcase
		// Single-board games drive both ports alike
		if (g == 8'd0 || g == 8'd3 || g == 8'd4 || g == 8'd6 || g == 8'd7)
			rb = ra;
		return {~ra, ~rb, bt};
	endfunction

	// Game byte in the upper half plus unsigned speech, scaled down by eight
	function automatic logic [15:0] mix_ref(input logic [7:0] ga, input logic [15:0] sp);
		return 16'((int'(ga) * 256 + int'(sp)) / 8);
	endfunction

	always_comb
	begin
		logic [15:0] an;
		an = exp_p2 ? joy2_analog : joy1_analog;
		exp_map = map_ref(exp_game, ctrl_mode, joy1, joy2, sg_state,
			stick_code(int'($signed(an[7:0]))), stick_code(-int'($signed(an[15:8]))));
		exp_flags = {exp_game == 8'd2, exp_game == 8'd6,
			!(exp_game == 8'd6 || exp_game == 8'd7)};
		exp_sw = exp_dip | {6'b0, joy1.advance | joy2.advance, joy1.autoup | joy2.autoup};
		exp_sin = ~{joy1.fire_a | joy2.fire_a, joy1.fire_b | joy2.fire_b};
		aud_diff = (audio_l > exp_audio) ? audio_l - exp_audio : exp_audio - audio_l;
	end

	////////////////////
	// Registered reference models
	always @(posedge clk_sys)
	begin
		exp_audio <= mix_ref(game_audio, speech);
		if (!rst_n)
		begin
			exp_game <= 8'd0;
			exp_dip <= 8'd0;
			exp_p2 <= 1'b0;
			aud_raw_ok <= 1'b0;
			{m_hs_d, m_vs_line, m_hblank, m_vblank, m_pcnt, m_lcnt} <= '0;
		end
		else
		begin
			aud_raw_ok <= (exp_game != 8'd6);
			if (dl_wr && dl_index == 8'd1)
				exp_game <= dl_data;
			if (dl_wr && dl_index == 8'd254 && dl_addr == 25'd0)
				exp_dip <= dl_data;
			if (joy1 != '0)
				exp_p2 <= 1'b0;
			else if (joy2 != '0)
				exp_p2 <= 1'b1;
			// Counters locked to sync rising edges
			m_hs_d <= hs;
			if (hs && !m_hs_d)
			begin
				m_pcnt <= '0;
				m_vs_line <= vs;
				if (vs && !m_vs_line)
					m_lcnt <= '0;
				else if (m_lcnt != 11'h7ff)
					m_lcnt <= m_lcnt + 11'd1;
			end
			else if (m_pcnt != 11'h7ff)
				m_pcnt <= m_pcnt + 11'd1;
			if (m_pcnt[10:1] == 10'd336) m_hblank <= 1'b1;
			if (m_pcnt[10:1] == 10'd40) m_hblank <= 1'b0;
			if (m_lcnt == 11'd254) m_vblank <= 1'b1;
			if (m_lcnt == 11'd14) m_vblank <= 1'b0;
		end
	end

	task automatic report_mismatch(input string what, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		errors++;
		$display("FAILED %s %s expected %0h actual %0h", test_name, what, exp_v, act_v);
	endtask

	////////////////////
	// Checks
	a_map: assert property (@(posedge clk_sys) disable iff (!rst_n) {ja, jb, btn} == exp_map)
		else report_mismatch("map", $sampled(exp_map), $sampled({ja, jb, btn}));
	a_sw: assert property (@(posedge clk_sys) disable iff (!rst_n) sw == exp_sw)
		else report_mismatch("sw", $sampled(exp_sw), $sampled(sw));
	a_flags: assert property (@(posedge clk_sys) disable iff (!rst_n)
		{blitter_sc2, sinistar, landscape} == exp_flags)
		else report_mismatch("flags", $sampled(exp_flags),
			$sampled({blitter_sc2, sinistar, landscape}));
	a_sin_buttons: assert property (@(posedge clk_sys) disable iff (!rst_n)
		{sin_fire, sin_bomb} == exp_sin)
		else report_mismatch("sinistar buttons", $sampled(exp_sin),
			$sampled({sin_fire, sin_bomb}));
	a_video: assert property (@(posedge clk_sys) disable iff (!rst_n)
		{hblank, vblank, ce_pix} == {m_hblank, m_vblank, m_pcnt[0]})
		else report_mismatch("video", $sampled({m_hblank, m_vblank, m_pcnt[0]}),
			$sampled({hblank, vblank, ce_pix}));
	a_audio_raw: assert property (@(posedge clk_sys) disable iff (!rst_n || !aud_raw_ok)
		audio_l == exp_audio)
		else report_mismatch("audio", $sampled(exp_audio), $sampled(audio_l));
	a_audio_lpf: assert property (@(posedge clk_sys) disable iff (!sin_chk) aud_diff <= 16'd2)
		else report_mismatch("filtered audio", $sampled(exp_audio), $sampled(audio_l));

	task automatic download(input logic [7:0] idx, input logic [24:0] addr, input logic [7:0] d);
		@(posedge clk_sys);
		dl_wr <= 1'b1;
		dl_index <= idx;
		dl_addr <= addr;
		dl_data <= d;
		@(posedge clk_sys);
		dl_wr <= 1'b0;
	endtask

	// One random control vector; keep_p1 zero holds player 1 idle
	task automatic drive_random(input logic keep_p1, input logic centered);
		rng = lcg_next(rng);
		joy1 <= keep_p1 ? joy_word_t'(rng[31:16]) : joy_word_t'(16'h0);
		joy1_analog <= centered ? 16'h0 : rng[15:0];
		sg_state <= rng[7];
		rng = lcg_next(rng);
		joy2 <= joy_word_t'(rng[31:16] | (keep_p1 ? 16'h0 : 16'h0001));
		joy2_analog <= centered ? 16'h0 : rng[15:0];
		@(posedge clk_sys);
	endtask

	initial
	begin
		#WATCHDOG_NS;
		$display("Watchdog expired before the tests finished");
		$display("Regression failed");
		$finish;
	end

	initial
	begin
		rng = 32'hf88e;
		errors = 0;
		tests = 0;
		sin_chk = 1'b0;
		test_name = "reset";
		{rst_n, dl_wr, dl_index, dl_addr, dl_data, sg_state, hs, vs} = '0;
		{joy1, joy2, joy1_analog, joy2_analog, game_audio, speech} = '0;
		ctrl_mode = ctrl_move_fire;
		repeat (4) @(posedge clk_sys);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk_sys);
		test_name = "config";
		tests++;
		download(8'd254, 25'd0, 8'ha5);
		download(8'd254, 25'd3, 8'h5a);
		repeat (4) @(posedge clk_sys);
		test_name = "mapping";
		tests++;
		for (int g = 0; g < 8; g++)
		begin
			download(8'd1, 25'd0, 8'(g));
			for (int mode = 0; mode < 4; mode++)
			begin
				ctrl_mode <= ctrl_mode_e'(mode);
				repeat (30) drive_random(1'b1, 1'b0);
			end
		end
		test_name = "sinistar_analog";
		tests++;
		download(8'd1, 25'd0, 8'd6);
		repeat (40) drive_random(1'b1, 1'b0);
		repeat (40) drive_random(1'b1, 1'b1);
		repeat (40) drive_random(1'b0, 1'b0);
		test_name = "video";
		tests++;
		for (int line = 0; line < 290; line++)
		begin
			for (int c = 0; c < 900; c++)
			begin
				hs <= (c < 64);
				if (c == 0)
					vs <= ((line % 270) < 3);
				@(posedge clk_sys);
			end
		end
		test_name = "audio_raw";
		tests++;
		download(8'd1, 25'd0, 8'd0);
		repeat (200)
		begin
			rng = lcg_next(rng);
			game_audio <= rng[23:16];
			speech <= rng[15:0];
			@(posedge clk_sys);
		end
		test_name = "audio_filtered";
		tests++;
		download(8'd1, 25'd0, 8'd6);
		game_audio <= 8'h20;
		speech <= 16'h9000;
		repeat (96 * 256) @(posedge clk_sys);
		sin_chk <= 1'b1;
		repeat (4) @(posedge clk_sys);
		sin_chk <= 1'b0;
		repeat (2) @(posedge clk_sys);
		$display("Tests run: %0d, errors: %0d", tests, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/arcade_io_top.sv
// I/O glue top level
// Download configuration, stick quantizer, control mapper,
// video timing and audio mixer
`timescale 1ns/1ns
`default_nettype none

module arcade_io_top (
	input  wire                       clk_sys,
	input  wire                       rst_n,
	input  wire                       dl_wr,
	input  wire [7:0]                 dl_index,
	input  wire [24:0]                dl_addr,
	input  wire [7:0]                 dl_data,
	input  wire game_pkg::joy_word_t  joy1,
	input  wire game_pkg::joy_word_t  joy2,
	input  wire [15:0]                joy1_analog,
	input  wire [15:0]                joy2_analog,
	input  wire game_pkg::ctrl_mode_e ctrl_mode,
	input  wire                       sg_state,
	input  wire                       hs,
	input  wire                       vs,
	input  wire [7:0]                 game_audio,
	input  wire [15:0]                speech,
	output game_pkg::ctrl_byte_t      ja,
	output game_pkg::ctrl_byte_t      jb,
	output logic [2:0]                btn,
	output logic [7:0]                sw,
	output logic                      blitter_sc2,
	output logic                      sinistar,
	output logic                      landscape,
	output logic                      sin_fire,
	output logic                      sin_bomb,
	output logic                      hblank,
	output logic                      vblank,
	output logic                      ce_pix,
	output logic [15:0]               audio_l
);
	import game_pkg::*;

	game_id_e   game;
	logic [7:0] dip;
	logic [3:0] stick_x;
	logic [3:0] stick_y;

	game_config u_game_config (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.dl_wr    (dl_wr),
		.dl_index (dl_index),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.game     (game),
		.dip      (dip)
	);

	stick_quantizer u_stick_quantizer (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.joy1        (joy1),
		.joy2        (joy2),
		.joy1_analog (joy1_analog),
		.joy2_analog (joy2_analog),
		.stick_x     (stick_x),
		.stick_y     (stick_y)
	);

	control_mapper u_control_mapper (
		.game        (game),
		.ctrl_mode   (ctrl_mode),
		.joy1        (joy1),
		.joy2        (joy2),
		.dip         (dip),
		.sg_state    (sg_state),
		.stick_x     (stick_x),
		.stick_y     (stick_y),
		.ja          (ja),
		.jb          (jb),
		.btn         (btn),
		.sw          (sw),
		.blitter_sc2 (blitter_sc2),
		.sinistar    (sinistar),
		.landscape   (landscape),
		.sin_fire    (sin_fire),
		.sin_bomb    (sin_bomb)
	);

	video_timing u_video_timing (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.hs      (hs),
		.vs      (vs),
		.hblank  (hblank),
		.vblank  (vblank),
		.ce_pix  (ce_pix)
	);

	audio_mixer u_audio_mixer (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.game       (game),
		.game_audio (game_audio),
		.speech     (speech),
		.audio_l    (audio_l)
	);

endmodule

`default_nettype wire

// File: logic/audio_mixer.sv
// Audio mixer
// Speech through two low-pass stages, used for Sinistar only,
// then summed with the game sound byte
`timescale 1ns/1ns
`default_nettype none
`include "arcade_settings.svh"

module audio_mixer (
	input  wire                clk_sys,
	input  wire                rst_n,
	input  wire game_pkg::game_id_e game,
	input  wire [7:0]          game_audio,
	input  wire [15:0]         speech,
	output logic [15:0]        audio_l
);
	import game_pkg::*;
	import audio_pkg::*;

	sample_t     speech_s;
	sample_t     stage1_out;
	sample_t     stage2_out;
	logic [15:0] filt_u;
	logic [15:0] speech_sel;
	logic [16:0] aud_sum;

	// Midscale offset to and from two's complement
	assign speech_s = sample_t'(speech - 16'h8000);

	speech_lpf u_stage1 (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.a2         (`ARC_S1_A2),
		.a3         (`ARC_S1_A3),
		.b1         (`ARC_S1_B1),
		.b2         (`ARC_S1_B2),
		.b3         (`ARC_S1_B3),
		.sample_in  (speech_s),
		.sample_out (stage1_out)
	);

	speech_lpf u_stage2 (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.a2         (`ARC_S2_A2),
		.a3         (`ARC_S2_A3),
		.b1         (`ARC_S2_B1),
		.b2         (`ARC_S2_B2),
		.b3         (`ARC_S2_B3),
		.sample_in  (stage1_out),
		.sample_out (stage2_out)
	);

	assign filt_u     = 16'(stage2_out) + 16'h8000;
	assign speech_sel = (game == game_sinistar) ? filt_u : speech;
	assign aud_sum    = {1'b0, game_audio, 8'd0} + {1'b0, speech_sel};

	always_ff @(posedge clk_sys)
	begin
		audio_l <= {2'b00, aud_sum[16:3]};
	end

endmodule

`default_nettype wire

// File: logic/speech_lpf.sv
// Second-order IIR low-pass stage
// Direct form biquad with its own sample-rate divider,
// coefficients scaled by 2^15 and a saturated 16-bit output
`timescale 1ns/1ns
`default_nettype none
`include "arcade_settings.svh"

module speech_lpf (
	input  wire                    clk_sys,
	input  wire                    rst_n,
	input  wire audio_pkg::coeff_t a2,
	input  wire audio_pkg::coeff_t a3,
	input  wire audio_pkg::coeff_t b1,
	input  wire audio_pkg::coeff_t b2,
	input  wire audio_pkg::coeff_t b3,
	input  wire audio_pkg::sample_t sample_in,
	output audio_pkg::sample_t     sample_out
);
	import audio_pkg::*;

	localparam int DIV_W = $clog2(`ARC_SPEECH_DIV);

	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	sample_t          x1;
	sample_t          x2;
	sample_t          y1;
	sample_t          y2;
	acc_t             acc;
	acc_t             scaled;
	sample_t          y_new;

	////////////////////
	// Sample-rate divider
	assign tick = (div_cnt == DIV_W'(`ARC_SPEECH_DIV - 1));

	always_ff @(posedge clk_sys)
	begin
		if (!rst_n || tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	////////////////////
	// y = b1*x + b2*x1 + b3*x2 - a2*y1 - a3*y2
	always_comb
	begin
		acc = acc_t'(b1) * acc_t'(sample_in)
			+ acc_t'(b2) * acc_t'(x1)
			+ acc_t'(b3) * acc_t'(x2)
			- acc_t'(a2) * acc_t'(y1)
			- acc_t'(a3) * acc_t'(y2);
		scaled = acc >>> `ARC_COEFF_SHIFT;
		// Clip to the sample range
		if (scaled > acc_t'(32767))
			y_new = 16'sh7fff;
		else if (scaled < acc_t'(-32768))
			y_new = -16'sh8000;
		else
			y_new = sample_t'(scaled);
	end

	// Filter history, y1 doubles as the output register
	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
		begin
			x1 <= '0;
			x2 <= '0;
			y1 <= '0;
			y2 <= '0;
		end
		else if (tick)
		begin
			x1 <= sample_in;
			x2 <= x1;
			y1 <= y_new;
			y2 <= y1;
		end
	end

	assign sample_out = y1;

endmodule

`default_nettype wire

// File: logic/video_timing.sv
// Video timing recovery
// Pixel and line counters locked to the game's sync pulses,
// registered blanking and the pixel clock enable
`timescale 1ns/1ns
`default_nettype none
`include "arcade_settings.svh"

module video_timing (
	input  wire  clk_sys,
	input  wire  rst_n,
	input  wire  hs,
	input  wire  vs,
	output logic hblank,
	output logic vblank,
	output logic ce_pix
);
	logic        hs_d;
	logic        vs_d;
	logic        hs_rise;
	logic [10:0] pcnt;
	logic [10:0] lcnt;

	assign hs_rise = hs & ~hs_d;

	// Two clocks per pixel
	assign ce_pix = pcnt[0];

	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
		begin
			hs_d   <= 1'b0;
			vs_d   <= 1'b0;
			pcnt   <= '0;
			lcnt   <= '0;
			hblank <= 1'b0;
			vblank <= 1'b0;
		end
		else
		begin
			hs_d <= hs;
			if (hs_rise)
			begin
				pcnt <= '0;
				// vs is only looked at on line starts
				vs_d <= vs;
				if (vs & ~vs_d)
					lcnt <= '0;
				else if (~&lcnt)
					lcnt <= lcnt + 11'd1;
			end
			else if (~&pcnt)
			begin
				pcnt <= pcnt + 11'd1;
			end

			if (pcnt[10:1] == `ARC_HBLANK_ON)
				hblank <= 1'b1;
			if (pcnt[10:1] == `ARC_HBLANK_OFF)
				hblank <= 1'b0;

			if (lcnt == `ARC_VBLANK_ON)
				vblank <= 1'b1;
			if (lcnt == `ARC_VBLANK_OFF)
				vblank <= 1'b0;
		end
	end

	// Blanking edges line up with the compare positions only
	a_hblank_at_compare: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		($past(rst_n) && !$stable(hblank)) |->
			($past(pcnt[10:1]) == `ARC_HBLANK_ON || $past(pcnt[10:1]) == `ARC_HBLANK_OFF)
	);

endmodule

`default_nettype wire

// File: logic/control_mapper.sv
// Per-game control mapping
// Builds the active-low JA, JB and BTN inputs, the switch byte and
// the board flags from both joysticks, the DIP byte and the stick position
`timescale 1ns/1ns
`default_nettype none

module control_mapper (
	input  wire game_pkg::game_id_e   game,
	input  wire game_pkg::ctrl_mode_e ctrl_mode,
	input  wire game_pkg::joy_word_t  joy1,
	input  wire game_pkg::joy_word_t  joy2,
	input  wire [7:0]                 dip,
	input  wire                       sg_state,
	input  wire [3:0]                 stick_x,
	input  wire [3:0]                 stick_y,
	output game_pkg::ctrl_byte_t      ja,
	output game_pkg::ctrl_byte_t      jb,
	output logic [2:0]                btn,
	output logic [7:0]                sw,
	output logic                      blitter_sc2,
	output logic                      sinistar,
	output logic                      landscape,
	output logic                      sin_fire,
	output logic                      sin_bomb
);
	import game_pkg::*;

	joy_word_t  m;
	logic       alt_fire;
	logic       second;
	logic       sg_thrust;
	logic       sg_reverse;
	logic [3:0] dig_x;
	logic [3:0] dig_y;
	logic [3:0] pos_x;
	logic [3:0] pos_y;

	// Direction nibble in board order
	function automatic logic [3:0] dirs(input joy_word_t j);
		return {j.right, j.left, j.down, j.up};
	endfunction

	// Fire buttons used as a four-way fire stick
	function automatic logic [3:0] fire_dirs(input joy_word_t j);
		return {j.fire_a, j.fire_d, j.fire_b, j.fire_c};
	endfunction

	// Both players merged
	assign m        = joy1 | joy2;
	assign alt_fire = ctrl_mode[0];
	assign second   = ctrl_mode[1];

	////////////////////
	// Stargate thrust and reverse
	// With sg_state the ship faces the other way and the stick follows it
	assign sg_thrust = (ctrl_mode == ctrl_twin_stick) ? m.fire_e :
		alt_fire ? (sg_state ? m.right : m.left) : (m.left | m.right);
	assign sg_reverse = alt_fire ? (sg_state ? m.left : m.right) : m.fire_b;

	////////////////////
	// Sinistar position, digital stick when analog is centered
	assign dig_x = m.left ? 4'd0 : (m.right ? 4'd8 : 4'd7);
	assign dig_y = m.down ? 4'd0 : (m.up ? 4'd8 : 4'd7);
	assign pos_x = (stick_x == 4'd7) ? dig_x : stick_x;
	assign pos_y = (stick_y == 4'd7) ? dig_y : stick_y;

	assign sw       = dip | {6'b0, m.advance, m.autoup};
	assign sin_fire = ~m.fire_a;
	assign sin_bomb = ~m.fire_b;

	always_comb
	begin
		ja          = '0;
		jb          = '0;
		btn         = 3'b000;
		blitter_sc2 = 1'b0;
		sinistar    = 1'b0;
		landscape   = 1'b1;
		case (game)
			game_robotron:
			begin
				btn = {m.start1, m.start2, m.coin};
				ja  = ~{second ? dirs(joy2) : (alt_fire ? dirs(m) : fire_dirs(m)),
					second ? dirs(joy1) : dirs(m)};
				jb  = ja;
			end
			game_joust:
			begin
				btn = {m.start2, m.start1, m.coin};
				ja  = ~{5'b00000, joy1.fire_a, joy1.right, joy1.left};
				jb  = ~{5'b00000, joy2.fire_a, joy2.right, joy2.left};
			end
			game_splat:
			begin
				blitter_sc2 = 1'b1;
				btn = {m.start1, m.start2, m.coin};
				ja  = ~{alt_fire ? dirs(joy1) : fire_dirs(joy1), dirs(joy1)};
				jb  = ~{alt_fire ? dirs(joy2) : fire_dirs(joy2), dirs(joy2)};
			end
			game_bubbles:
			begin
				btn = {m.start2, m.start1, m.coin};
				ja  = ~{4'b0000, dirs(m)};
				jb  = ja;
			end
			game_stargate:
			begin
				btn = {m.start2, m.start1, m.coin};
				ja  = ~{m.fire_f, m.up, m.down, sg_thrust,
					m.fire_d, m.fire_c, sg_reverse, m.fire_a};
				jb  = ja;
			end
			game_alienar:
			begin
				btn = {m.start1, m.start2, m.coin};
				ja  = ~{2'b00, joy1.fire_b, joy1.fire_a, dirs(joy1)};
				jb  = ~{2'b00, joy2.fire_b, joy2.fire_a, dirs(joy2)};
			end
			game_sinistar:
			begin
				sinistar  = 1'b1;
				landscape = 1'b0;
				btn = {m.start1, m.start2, m.coin};
				ja  = ~{pos_x, pos_y};
				jb  = ja;
			end
			game_playball:
			begin
				landscape = 1'b0;
				btn = {2'b00, m.coin};
				ja  = ~{4'b0000, m.start2, m.right, m.left, m.start1};
				jb  = ja;
			end
			default:
			begin
				ja = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: logic/stick_quantizer.sv
// Analog stick quantizer for Sinistar
// Follows whichever player moved last and maps each axis to the
// 4-bit stick positions of the original 49-way joystick
`timescale 1ns/1ns
`default_nettype none
`include "arcade_settings.svh"

module stick_quantizer (
	input  wire                 clk_sys,
	input  wire                 rst_n,
	input  wire game_pkg::joy_word_t joy1,
	input  wire game_pkg::joy_word_t joy2,
	input  wire [15:0]          joy1_analog,
	input  wire [15:0]          joy2_analog,
	output logic [3:0]          stick_x,
	output logic [3:0]          stick_y
);
	import game_pkg::*;

	logic        use_p2;
	logic [15:0] analog;

	// Low codes on the negative side for X, mirrored for Y
	function automatic logic [3:0] quantize(input logic signed [7:0] v, input logic mirror);
		logic [3:0] neg_far;
		logic [3:0] neg_mid;
		logic [3:0] neg_near;
		logic [3:0] pos_far;
		logic [3:0] pos_mid;
		logic [3:0] pos_near;
		neg_far  = mirror ? 4'd8  : 4'd0;
		neg_mid  = mirror ? 4'd9  : 4'd4;
		neg_near = mirror ? 4'd11 : 4'd6;
		pos_far  = mirror ? 4'd0  : 4'd8;
		pos_mid  = mirror ? 4'd4  : 4'd9;
		pos_near = mirror ? 4'd6  : 4'd11;
		if (v < -`ARC_STICK_T3)
			return neg_far;
		else if (v < -`ARC_STICK_T2)
			return neg_mid;
		else if (v < -`ARC_STICK_T1)
			return neg_near;
		else if (v > `ARC_STICK_T3)
			return pos_far;
		else if (v > `ARC_STICK_T2)
			return pos_mid;
		else if (v > `ARC_STICK_T1)
			return pos_near;
		return 4'd7;
	endfunction

	// Player 1 activity wins when both move together
	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
			use_p2 <= 1'b0;
		else if (joy1 != '0)
			use_p2 <= 1'b0;
		else if (joy2 != '0)
			use_p2 <= 1'b1;
	end

	assign analog  = use_p2 ? joy2_analog : joy1_analog;
	assign stick_x = quantize(analog[7:0], 1'b0);
	assign stick_y = quantize(analog[15:8], 1'b1);

	// Stick source moves only after joystick activity
	a_source_on_activity: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		!$stable(use_p2) |-> $past(joy1 != '0 || joy2 != '0)
	);

endmodule

`default_nettype wire

// File: logic/game_config.sv
// Game configuration registers
// Game selector from download index 1
// DIP-switch byte from download index 254, address 0 only
`timescale 1ns/1ns
`default_nettype none
`include "arcade_settings.svh"

module game_config (
	input  wire                clk_sys,
	input  wire                rst_n,
	input  wire                dl_wr,
	input  wire [7:0]          dl_index,
	input  wire [24:0]         dl_addr,
	input  wire [7:0]          dl_data,
	output game_pkg::game_id_e game,
	output logic [7:0]         dip
);
	import game_pkg::*;

	logic game_wr;
	logic dip_wr;

	assign game_wr = dl_wr && (dl_index == `ARC_DL_GAME_INDEX);

	// The board has eight DIP banks, only bank 0 is wired
	assign dip_wr = dl_wr && (dl_index == `ARC_DL_DIP_INDEX)
		&& (dl_addr[24:3] == '0) && (dl_addr[2:0] == 3'd0);

	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
		begin
			game <= game_robotron;
			dip  <= 8'd0;
		end
		else
		begin
			if (game_wr)
				game <= game_id_e'(dl_data);
			if (dip_wr)
				dip <= dl_data;
		end
	end

	////////////////////
	// Checks

	// Selector moves only as the result of a game download
	a_game_from_download: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		($past(rst_n) && !$stable(game)) |-> $past(game_wr)
	);

endmodule

`default_nettype wire

// File: logic/audio_pkg.sv
// Audio types
// Samples, filter coefficients and the filter accumulator
`default_nettype none

package audio_pkg;

	// Signed sample, full scale at 16 bits
	typedef logic signed [15:0] sample_t;

	// Filter coefficient, 1.0 equals 2^15
	typedef logic signed [21:0] coeff_t;

	// Wide enough for five coefficient products
	typedef logic signed [39:0] acc_t;

endpackage

`default_nettype wire

// File: logic/game_pkg.sv
// Game and controller types
// Game identifier, control option and the joystick and board input words
`default_nettype none

package game_pkg;

	// Value loaded through download index 1
	typedef enum logic [7:0] {
		game_robotron = 8'd0,
		game_joust    = 8'd1,
		game_splat    = 8'd2,
		game_bubbles  = 8'd3,
		game_stargate = 8'd4,
		game_alienar  = 8'd5,
		game_sinistar = 8'd6,
		game_playball = 8'd7
	} game_id_e;

	// Bit 0 picks the alternate fire source, bit 1 the second stick
	// or cabinet layout
	typedef enum logic [1:0] {
		ctrl_move_fire  = 2'd0,
		ctrl_move_only  = 2'd1,
		ctrl_twin_stick = 2'd2,
		ctrl_extra_fire = 2'd3
	} ctrl_mode_e;

	// One player's digital controls, right in bit 0
	typedef struct packed {
		logic pause;
		logic autoup;
		logic advance;
		logic coin;
		logic start2;
		logic start1;
		logic fire_f;
		logic fire_e;
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_word_t;

	// Board input byte, active low
	typedef logic [7:0] ctrl_byte_t;

endpackage

`default_nettype wire

// File: include/arcade_settings.svh
// Build constants for the Williams I/O glue
// Download indices, analog stick thresholds, blanking positions,
// speech sample divider and the two speech filter stages
`ifndef ARCADE_SETTINGS_SVH
`define ARCADE_SETTINGS_SVH

////////////////////
// Download indices
`define ARC_DL_GAME_INDEX 8'd1
`define ARC_DL_DIP_INDEX  8'd254

// Analog stick steps, in signed counts from center
`define ARC_STICK_T1 32
`define ARC_STICK_T2 64
`define ARC_STICK_T3 96

////////////////////
// Horizontal positions count half pixels, vertical positions count lines
`define ARC_HBLANK_ON  10'd336
`define ARC_HBLANK_OFF 10'd40
`define ARC_VBLANK_ON  11'd254
`define ARC_VBLANK_OFF 11'd14

////////////////////
// Speech filter runs at clk_sys / 256
`define ARC_SPEECH_DIV  256
`define ARC_COEFF_SHIFT 15

// Stage 1 near 3.47 kHz, Q about 0.69
`define ARC_S1_A2 (-22'sd44264)
`define ARC_S1_A3 (22'sd16763)
`define ARC_S1_B1 (22'sd1317)
`define ARC_S1_B2 (22'sd2633)
`define ARC_S1_B3 (22'sd1317)

// Stage 2 near 3.33 kHz, Q about 0.70
`define ARC_S2_A2 (-22'sd45172)
`define ARC_S2_A3 (22'sd17306)
`define ARC_S2_B1 (22'sd1225)
`define ARC_S2_B2 (22'sd2452)
`define ARC_S2_B3 (22'sd1225)

`endif
